//--- lc4_pkg.sv
`default_nettype none

package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;

    // major opcodes in insn[15:12]
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_MUL, ALU_SUB, ALU_ADDI,
        ALU_AND, ALU_NOT, ALU_OR, ALU_XOR, ALU_ANDI,
        ALU_PASS_B,
        // base plus offset for LDR and STR
        ALU_ADDR
    } alu_op_e;

    typedef struct packed {
        logic [REG_SEL_W-1:0] rs_sel;
        logic [REG_SEL_W-1:0] rt_sel;
        logic [REG_SEL_W-1:0] rd_sel;
        logic                 rs_re;
        logic                 rt_re;
        logic                 rd_we;
        logic                 is_load;
        logic                 is_store;
        alu_op_e              alu_op;
        logic [WORD_W-1:0]    imm;
        logic [WORD_W-1:0]    insn;
    } insn_ctl_t;

    // trace stall codes, 1 is unused with a single pipe and no branches
    typedef enum logic [1:0] {
        STALL_NONE = 2'd0,
        STALL_FILL = 2'd2,
        STALL_LOAD = 2'd3
    } stall_e;

    typedef enum logic [1:0] {FWD_REG, FWD_M, FWD_W} fwd_e;

endpackage

`default_nettype wire

//--- lc4_pipe_ctl_if.sv
`default_nettype none

// decisions of the hazard controller, one modport per consumer stage
interface lc4_pipe_ctl_if;

    logic            hold_fd;
    logic            x_bubble;
    lc4_pkg::fwd_e   rs_fwd;
    lc4_pkg::fwd_e   rt_fwd;
    // store data select for the store sitting in memory
    lc4_pkg::fwd_e   st_fwd;

    modport ctrl (output hold_fd, x_bubble, rs_fwd, rt_fwd, st_fwd);
    modport fetch (input hold_fd);
    modport exec (input x_bubble, rs_fwd, rt_fwd);
    modport memwb (input st_fwd);

endinterface

`default_nettype wire

//--- lc4_decoder.sv
`default_nettype none

module lc4_decoder (
    input  wire [lc4_pkg::WORD_W-1:0] i_insn,
    output lc4_pkg::insn_ctl_t        o_ctl
);

    lc4_pkg::alu_op_e grp_op;
    logic             grp_ok;
    logic             is_logic;

    assign is_logic = (i_insn[15:12] == lc4_pkg::OP_LOGIC);

    // sub-op of the arithmetic and logic groups, DIV is not kept
    always_comb begin
        grp_op = lc4_pkg::ALU_ADD;
        grp_ok = 1'b1;
        casez ({is_logic, i_insn[5:3]})
            4'b0000: grp_op = lc4_pkg::ALU_ADD;
            4'b0001: grp_op = lc4_pkg::ALU_MUL;
            4'b0010: grp_op = lc4_pkg::ALU_SUB;
            4'b01??: grp_op = lc4_pkg::ALU_ADDI;
            4'b1000: grp_op = lc4_pkg::ALU_AND;
            4'b1001: grp_op = lc4_pkg::ALU_NOT;
            4'b1010: grp_op = lc4_pkg::ALU_OR;
            4'b1011: grp_op = lc4_pkg::ALU_XOR;
            4'b11??: grp_op = lc4_pkg::ALU_ANDI;
            default: grp_ok = 1'b0;
        endcase
    end

    always_comb begin
        o_ctl        = '0;
        o_ctl.insn   = i_insn;
        o_ctl.rs_sel = i_insn[8:6];
        o_ctl.rt_sel = i_insn[2:0];
        o_ctl.rd_sel = i_insn[11:9];
        o_ctl.alu_op = lc4_pkg::ALU_PASS_B;
        o_ctl.imm    = {{11{i_insn[4]}}, i_insn[4:0]};
        case (i_insn[15:12])
            lc4_pkg::OP_ARITH, lc4_pkg::OP_LOGIC: begin
                if (grp_ok) begin
                    o_ctl.rs_re  = 1'b1;
                    o_ctl.rt_re  = !i_insn[5] && (grp_op != lc4_pkg::ALU_NOT);
                    o_ctl.rd_we  = 1'b1;
                    o_ctl.alu_op = grp_op;
                end
            end
            lc4_pkg::OP_LDR: begin
                o_ctl.rs_re   = 1'b1;
                o_ctl.rd_we   = 1'b1;
                o_ctl.is_load = 1'b1;
                o_ctl.alu_op  = lc4_pkg::ALU_ADDR;
                o_ctl.imm     = {{10{i_insn[5]}}, i_insn[5:0]};
            end
            lc4_pkg::OP_STR: begin
                // the data register sits where rd would be
                o_ctl.rt_sel   = i_insn[11:9];
                o_ctl.rs_re    = 1'b1;
                o_ctl.rt_re    = 1'b1;
                o_ctl.is_store = 1'b1;
                o_ctl.alu_op   = lc4_pkg::ALU_ADDR;
                o_ctl.imm      = {{10{i_insn[5]}}, i_insn[5:0]};
            end
            lc4_pkg::OP_CONST: begin
                o_ctl.rd_we = 1'b1;
                o_ctl.imm   = {{7{i_insn[8]}}, i_insn[8:0]};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- lc4_regfile.sv
`default_nettype none

module lc4_regfile (
    input  wire                          gwe,
    input  wire                          i_reset,
    input  wire [lc4_pkg::REG_SEL_W-1:0] i_rs_sel,
    input  wire [lc4_pkg::REG_SEL_W-1:0] i_rt_sel,
    output logic [lc4_pkg::WORD_W-1:0]   o_rs_data,
    output logic [lc4_pkg::WORD_W-1:0]   o_rt_data,
    input  wire [lc4_pkg::REG_SEL_W-1:0] i_rd_sel,
    input  wire                          i_rd_we,
    input  wire [lc4_pkg::WORD_W-1:0]    i_rd_data
);

    logic [lc4_pkg::WORD_W-1:0] regs [lc4_pkg::NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

    a_wsel_known: assert property (@(posedge gwe) disable iff (i_reset)
        i_rd_we |-> !$isunknown(i_rd_sel));

endmodule

`default_nettype wire

//--- lc4_alu.sv
`default_nettype none

module lc4_alu (
    input  wire lc4_pkg::alu_op_e       i_op,
    input  wire [lc4_pkg::WORD_W-1:0]   i_a,
    input  wire [lc4_pkg::WORD_W-1:0]   i_b,
    input  wire [lc4_pkg::WORD_W-1:0]   i_imm,
    output logic [lc4_pkg::WORD_W-1:0]  o_result
);

    // all results wrap at 16 bits
    always_comb begin
        case (i_op)
            lc4_pkg::ALU_ADD:    o_result = i_a + i_b;
            lc4_pkg::ALU_MUL:    o_result = i_a * i_b;
            lc4_pkg::ALU_SUB:    o_result = i_a - i_b;
            lc4_pkg::ALU_ADDI:   o_result = i_a + i_imm;
            lc4_pkg::ALU_AND:    o_result = i_a & i_b;
            lc4_pkg::ALU_NOT:    o_result = ~i_a;
            lc4_pkg::ALU_OR:     o_result = i_a | i_b;
            lc4_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            lc4_pkg::ALU_ANDI:   o_result = i_a & i_imm;
            lc4_pkg::ALU_PASS_B: o_result = i_imm;
            // memory address, base in rs
            lc4_pkg::ALU_ADDR:   o_result = i_a + i_imm;
            default:             o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- lc4_fetch_decode.sv
`default_nettype none

module lc4_fetch_decode #(
    parameter logic [lc4_pkg::WORD_W-1:0] RESET_PC = 16'h8200
) (
    input  wire                         gwe,
    input  wire                         i_reset,
    input  wire [lc4_pkg::WORD_W-1:0]   i_insn,
    lc4_pipe_ctl_if.fetch               ctl,
    output logic [lc4_pkg::WORD_W-1:0]  o_pc,
    output logic [lc4_pkg::WORD_W-1:0]  o_d_pc,
    output lc4_pkg::insn_ctl_t          o_d_ctl
);

    logic [lc4_pkg::WORD_W-1:0] d_insn;

    // a reset bubble leaves decode with pc and insn both zero
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_pc   <= RESET_PC;
            o_d_pc <= '0;
            d_insn <= '0;
        end else if (!ctl.hold_fd) begin
            o_pc   <= o_pc + 1'b1;
            o_d_pc <= o_pc;
            d_insn <= i_insn;
        end
    end

    lc4_decoder u_decoder (
        .i_insn (d_insn),
        .o_ctl  (o_d_ctl)
    );

endmodule

`default_nettype wire

//--- lc4_execute.sv
`default_nettype none

module lc4_execute (
    input  wire                         gwe,
    input  wire                         i_reset,
    lc4_pipe_ctl_if.exec                ctl,
    input  wire lc4_pkg::insn_ctl_t     i_d_ctl,
    input  wire [lc4_pkg::WORD_W-1:0]   i_d_pc,
    input  wire [lc4_pkg::WORD_W-1:0]   i_rs_data,
    input  wire [lc4_pkg::WORD_W-1:0]   i_rt_data,
    input  wire [lc4_pkg::WORD_W-1:0]   i_m_result,
    input  wire [lc4_pkg::WORD_W-1:0]   i_w_data,
    output lc4_pkg::insn_ctl_t          o_x_ctl,
    output logic [lc4_pkg::WORD_W-1:0]  o_x_pc,
    output lc4_pkg::stall_e             o_x_stall,
    output logic [lc4_pkg::WORD_W-1:0]  o_result,
    output logic [lc4_pkg::WORD_W-1:0]  o_rt_value
);

    logic [lc4_pkg::WORD_W-1:0] x_rs;
    logic [lc4_pkg::WORD_W-1:0] x_rt;
    logic [lc4_pkg::WORD_W-1:0] rs_val;
    logic                       d_fill;

    function automatic logic [lc4_pkg::WORD_W-1:0] pick(
        lc4_pkg::fwd_e              sel,
        logic [lc4_pkg::WORD_W-1:0] reg_val,
        logic [lc4_pkg::WORD_W-1:0] m_val,
        logic [lc4_pkg::WORD_W-1:0] w_val
    );
        case (sel)
            lc4_pkg::FWD_M: return m_val;
            lc4_pkg::FWD_W: return w_val;
            default:        return reg_val;
        endcase
    endfunction

    assign d_fill = (i_d_ctl.insn == '0) && (i_d_pc == '0);

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_x_ctl   <= '0;
            o_x_pc    <= '0;
            o_x_stall <= lc4_pkg::STALL_FILL;
        end else if (ctl.x_bubble) begin
            o_x_ctl   <= '0;
            o_x_pc    <= '0;
            o_x_stall <= lc4_pkg::STALL_LOAD;
        end else begin
            o_x_ctl   <= i_d_ctl;
            o_x_pc    <= i_d_pc;
            if (d_fill) begin
                o_x_stall <= lc4_pkg::STALL_FILL;
            end else begin
                o_x_stall <= lc4_pkg::STALL_NONE;
            end
        end
    end

    always_ff @(posedge gwe) begin
        x_rs <= i_rs_data;
        x_rt <= i_rt_data;
    end

    // MX and WX bypass
    assign rs_val     = pick(ctl.rs_fwd, x_rs, i_m_result, i_w_data);
    assign o_rt_value = pick(ctl.rt_fwd, x_rt, i_m_result, i_w_data);

    lc4_alu u_alu (
        .i_op     (o_x_ctl.alu_op),
        .i_a      (rs_val),
        .i_b      (o_rt_value),
        .i_imm    (o_x_ctl.imm),
        .o_result (o_result)
    );

endmodule

`default_nettype wire

//--- lc4_mem_wb.sv
`default_nettype none

module lc4_mem_wb (
    input  wire                            gwe,
    input  wire                            i_reset,
    lc4_pipe_ctl_if.memwb                  ctl,
    input  wire lc4_pkg::insn_ctl_t        i_x_ctl,
    input  wire [lc4_pkg::WORD_W-1:0]      i_x_pc,
    input  wire [lc4_pkg::WORD_W-1:0]      i_x_result,
    input  wire [lc4_pkg::WORD_W-1:0]      i_x_rt_value,
    input  wire lc4_pkg::stall_e           i_x_stall,
    input  wire [lc4_pkg::WORD_W-1:0]      i_dmem_data,
    output logic [lc4_pkg::WORD_W-1:0]     o_dmem_addr,
    output logic                           o_dmem_we,
    output logic [lc4_pkg::WORD_W-1:0]     o_dmem_towrite,
    output lc4_pkg::insn_ctl_t             o_m_ctl,
    output logic [lc4_pkg::WORD_W-1:0]     o_m_result,
    output lc4_pkg::insn_ctl_t             o_w_ctl,
    output logic [lc4_pkg::WORD_W-1:0]     o_w_data,
    output lc4_pkg::stall_e                o_test_stall,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_cur_pc,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_cur_insn,
    output logic                           o_test_regfile_we,
    output logic [lc4_pkg::REG_SEL_W-1:0]  o_test_regfile_wsel,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_regfile_data,
    output logic                           o_test_dmem_we,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_dmem_addr,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_dmem_data
);

    logic [lc4_pkg::WORD_W-1:0] m_pc;
    logic [lc4_pkg::WORD_W-1:0] m_rt;
    logic [lc4_pkg::WORD_W-1:0] m_dmem_data;
    logic [lc4_pkg::WORD_W-1:0] w_result;
    lc4_pkg::stall_e            m_stall;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_m_ctl       <= '0;
            m_pc          <= '0;
            m_stall       <= lc4_pkg::STALL_FILL;
            o_w_ctl       <= '0;
            o_test_cur_pc <= '0;
            o_test_stall  <= lc4_pkg::STALL_FILL;
        end else begin
            o_m_ctl       <= i_x_ctl;
            m_pc          <= i_x_pc;
            m_stall       <= i_x_stall;
            o_w_ctl       <= o_m_ctl;
            o_test_cur_pc <= m_pc;
            o_test_stall  <= m_stall;
        end
    end

    always_ff @(posedge gwe) begin
        o_m_result       <= i_x_result;
        m_rt             <= i_x_rt_value;
        w_result         <= o_m_result;
        o_test_dmem_addr <= o_dmem_addr;
        o_test_dmem_data <= m_dmem_data;
    end

    // WM bypass of store data from the instruction retiring now
    assign o_dmem_towrite = (ctl.st_fwd == lc4_pkg::FWD_W) ? o_w_data : m_rt;
    assign o_dmem_we      = o_m_ctl.is_store;
    assign o_dmem_addr    = (o_m_ctl.is_load || o_m_ctl.is_store) ? o_m_result : '0;

    // loaded word or stored word, as the trace reports it
    always_comb begin
        if (o_m_ctl.is_load) begin
            m_dmem_data = i_dmem_data;
        end else if (o_m_ctl.is_store) begin
            m_dmem_data = o_dmem_towrite;
        end else begin
            m_dmem_data = '0;
        end
    end

    assign o_w_data = o_w_ctl.is_load ? o_test_dmem_data : w_result;

    assign o_test_cur_insn     = o_w_ctl.insn;
    assign o_test_regfile_we   = o_w_ctl.rd_we;
    assign o_test_regfile_wsel = o_w_ctl.rd_sel;
    assign o_test_regfile_data = o_w_data;
    assign o_test_dmem_we      = o_w_ctl.is_store;

    a_no_store_on_load: assert property (@(posedge gwe) disable iff (i_reset)
        $rose(o_dmem_we) |-> !o_m_ctl.is_load);

endmodule

`default_nettype wire

//--- lc4_hazard_ctrl.sv
`default_nettype none

module lc4_hazard_ctrl (
    lc4_pipe_ctl_if.ctrl            ctl,
    input  wire lc4_pkg::insn_ctl_t i_d_ctl,
    input  wire lc4_pkg::insn_ctl_t i_x_ctl,
    input  wire lc4_pkg::insn_ctl_t i_m_ctl,
    input  wire lc4_pkg::insn_ctl_t i_w_ctl
);

    logic load_use;

    // memory stage wins since it holds the younger write
    function automatic lc4_pkg::fwd_e fwd_sel(
        logic                          re,
        logic [lc4_pkg::REG_SEL_W-1:0] sel,
        lc4_pkg::insn_ctl_t            m,
        lc4_pkg::insn_ctl_t            w
    );
        if (re && m.rd_we && m.rd_sel == sel) begin
            return lc4_pkg::FWD_M;
        end
        if (re && w.rd_we && w.rd_sel == sel) begin
            return lc4_pkg::FWD_W;
        end
        return lc4_pkg::FWD_REG;
    endfunction

    // store data of a dependent store is caught later by the WM bypass
    assign load_use = i_x_ctl.is_load && i_x_ctl.rd_we &&
        ((i_d_ctl.rs_re && i_d_ctl.rs_sel == i_x_ctl.rd_sel) ||
         (i_d_ctl.rt_re && !i_d_ctl.is_store && i_d_ctl.rt_sel == i_x_ctl.rd_sel));

    assign ctl.hold_fd  = load_use;
    assign ctl.x_bubble = load_use;

    assign ctl.rs_fwd = fwd_sel(i_x_ctl.rs_re, i_x_ctl.rs_sel, i_m_ctl, i_w_ctl);
    assign ctl.rt_fwd = fwd_sel(i_x_ctl.rt_re, i_x_ctl.rt_sel, i_m_ctl, i_w_ctl);
    assign ctl.st_fwd = (i_m_ctl.is_store && i_w_ctl.rd_we &&
                         i_w_ctl.rd_sel == i_m_ctl.rt_sel) ? lc4_pkg::FWD_W : lc4_pkg::FWD_REG;

endmodule

`default_nettype wire

//--- lc4_core.sv
`default_nettype none

module lc4_core #(
    parameter logic [lc4_pkg::WORD_W-1:0] RESET_PC = 16'h8200
) (
    input  wire                            gwe,
    input  wire                            i_reset,
    output logic [lc4_pkg::WORD_W-1:0]     o_cur_pc,
    input  wire [lc4_pkg::WORD_W-1:0]      i_cur_insn,
    output logic [lc4_pkg::WORD_W-1:0]     o_dmem_addr,
    input  wire [lc4_pkg::WORD_W-1:0]      i_cur_dmem_data,
    output logic                           o_dmem_we,
    output logic [lc4_pkg::WORD_W-1:0]     o_dmem_towrite,
    output logic [1:0]                     o_test_stall,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_cur_pc,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_cur_insn,
    output logic                           o_test_regfile_we,
    output logic [lc4_pkg::REG_SEL_W-1:0]  o_test_regfile_wsel,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_regfile_data,
    output logic                           o_test_dmem_we,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_dmem_addr,
    output logic [lc4_pkg::WORD_W-1:0]     o_test_dmem_data
);

    lc4_pkg::insn_ctl_t         d_ctl;
    lc4_pkg::insn_ctl_t         x_ctl;
    lc4_pkg::insn_ctl_t         m_ctl;
    lc4_pkg::insn_ctl_t         w_ctl;
    lc4_pkg::stall_e            x_stall;
    logic [lc4_pkg::WORD_W-1:0] d_pc;
    logic [lc4_pkg::WORD_W-1:0] x_pc;
    logic [lc4_pkg::WORD_W-1:0] rs_data;
    logic [lc4_pkg::WORD_W-1:0] rt_data;
    logic [lc4_pkg::WORD_W-1:0] x_result;
    logic [lc4_pkg::WORD_W-1:0] x_rt_value;
    logic [lc4_pkg::WORD_W-1:0] m_result;
    logic [lc4_pkg::WORD_W-1:0] w_data;

    lc4_pipe_ctl_if pipe_ctl ();

    lc4_fetch_decode #(.RESET_PC(RESET_PC)) u_fetch_decode (
        .gwe     (gwe),
        .i_reset (i_reset),
        .i_insn  (i_cur_insn),
        .ctl     (pipe_ctl.fetch),
        .o_pc    (o_cur_pc),
        .o_d_pc  (d_pc),
        .o_d_ctl (d_ctl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs_sel  (d_ctl.rs_sel),
        .i_rt_sel  (d_ctl.rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_rd_sel  (w_ctl.rd_sel),
        .i_rd_we   (w_ctl.rd_we),
        .i_rd_data (w_data)
    );

    lc4_execute u_execute (
        .gwe        (gwe),
        .i_reset    (i_reset),
        .ctl        (pipe_ctl.exec),
        .i_d_ctl    (d_ctl),
        .i_d_pc     (d_pc),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .i_m_result (m_result),
        .i_w_data   (w_data),
        .o_x_ctl    (x_ctl),
        .o_x_pc     (x_pc),
        .o_x_stall  (x_stall),
        .o_result   (x_result),
        .o_rt_value (x_rt_value)
    );

    lc4_mem_wb u_mem_wb (
        .gwe                 (gwe),
        .i_reset             (i_reset),
        .ctl                 (pipe_ctl.memwb),
        .i_x_ctl             (x_ctl),
        .i_x_pc              (x_pc),
        .i_x_result          (x_result),
        .i_x_rt_value        (x_rt_value),
        .i_x_stall           (x_stall),
        .i_dmem_data         (i_cur_dmem_data),
        .o_dmem_addr         (o_dmem_addr),
        .o_dmem_we           (o_dmem_we),
        .o_dmem_towrite      (o_dmem_towrite),
        .o_m_ctl             (m_ctl),
        .o_m_result          (m_result),
        .o_w_ctl             (w_ctl),
        .o_w_data            (w_data),
        .o_test_stall        (o_test_stall),
        .o_test_cur_pc       (o_test_cur_pc),
        .o_test_cur_insn     (o_test_cur_insn),
        .o_test_regfile_we   (o_test_regfile_we),
        .o_test_regfile_wsel (o_test_regfile_wsel),
        .o_test_regfile_data (o_test_regfile_data),
        .o_test_dmem_we      (o_test_dmem_we),
        .o_test_dmem_addr    (o_test_dmem_addr),
        .o_test_dmem_data    (o_test_dmem_data)
    );

    lc4_hazard_ctrl u_hazard_ctrl (
        .ctl     (pipe_ctl.ctrl),
        .i_d_ctl (d_ctl),
        .i_x_ctl (x_ctl),
        .i_m_ctl (m_ctl),
        .i_w_ctl (w_ctl)
    );

endmodule

`default_nettype wire

//--- tb_lc4_core.sv
`default_nettype none

module tb_lc4_core;

    localparam logic [15:0] RESET_PC   = 16'h8200;
    localparam int          PROG_LEN   = 200;
    // two cycles per instruction plus pipeline fill
    localparam int          MAX_CYCLES = 2 * PROG_LEN + 100;

    logic        gwe = 1'b0;
    logic        i_reset;
    logic [15:0] i_cur_insn;
    logic [15:0] i_cur_dmem_data;
    logic [15:0] o_cur_pc;
    logic [15:0] o_dmem_addr;
    logic        o_dmem_we;
    logic [15:0] o_dmem_towrite;
    logic [1:0]  o_test_stall;
    logic [15:0] o_test_cur_pc;
    logic [15:0] o_test_cur_insn;
    logic        o_test_regfile_we;
    logic [2:0]  o_test_regfile_wsel;
    logic [15:0] o_test_regfile_data;
    logic        o_test_dmem_we;
    logic [15:0] o_test_dmem_addr;
    logic [15:0] o_test_dmem_data;

    logic [15:0] prog [0:PROG_LEN-1];
    logic [15:0] dmem [0:255];
    logic [15:0] shadow_mem [0:255];
    logic [15:0] ref_regs [0:7];
    logic [31:0] lcg_state;

    // expected trace of the instruction being checked
    logic        exp_we;
    logic [2:0]  exp_wsel;
    logic [15:0] exp_wdata;
    logic        exp_dwe;
    logic        exp_mem;
    logic [15:0] exp_daddr;
    logic [15:0] exp_ddata;

    int cycles       = 0;
    int ret_idx      = 0;
    int bubbles_seen = 0;
    int value_errs   = 0;
    int stall_errs   = 0;
    int other_errs   = 0;
    logic stall_due  = 1'b0;
    logic done       = 1'b0;

    lc4_core #(.RESET_PC(RESET_PC)) dut_i (
        .gwe                 (gwe),
        .i_reset             (i_reset),
        .o_cur_pc            (o_cur_pc),
        .i_cur_insn          (i_cur_insn),
        .o_dmem_addr         (o_dmem_addr),
        .i_cur_dmem_data     (i_cur_dmem_data),
        .o_dmem_we           (o_dmem_we),
        .o_dmem_towrite      (o_dmem_towrite),
        .o_test_stall        (o_test_stall),
        .o_test_cur_pc       (o_test_cur_pc),
        .o_test_cur_insn     (o_test_cur_insn),
        .o_test_regfile_we   (o_test_regfile_we),
        .o_test_regfile_wsel (o_test_regfile_wsel),
        .o_test_regfile_data (o_test_regfile_data),
        .o_test_dmem_we      (o_test_dmem_we),
        .o_test_dmem_addr    (o_test_dmem_addr),
        .o_test_dmem_data    (o_test_dmem_data)
    );

    always #20 gwe = ~gwe;

    always @(posedge gwe) begin
        cycles <= cycles + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] fetch_word(input logic [15:0] pc);
        logic [15:0] off;
        off = pc - RESET_PC;
        if (off < PROG_LEN) begin
            return prog[off];
        end
        // opcode 0000 decodes as a no-op past the program
        return {4'b0000, pc[11:0] ^ {8'h00, pc[15:12]}};
    endfunction

    // data memory takes the store at the rising edge
    always @(posedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
        end
    end

    // both memories answer 2 units after the rising edge
    always @(posedge gwe) begin
        #2;
        i_cur_insn      = fetch_word(o_cur_pc);
        i_cur_dmem_data = dmem[o_dmem_addr[7:0]];
    end

    function automatic logic [15:0] enc_rrr(input logic [3:0] op, input logic [2:0] sub,
                                            input logic [1:0] d, input logic [1:0] s,
                                            input logic [1:0] t);
        return {op, 1'b0, d, 1'b0, s, sub, 1'b0, t};
    endfunction

    function automatic logic [15:0] enc_imm6(input logic [3:0] op, input logic [1:0] d,
                                             input logic [1:0] s, input logic [5:0] imm);
        return {op, 1'b0, d, 1'b0, s, imm};
    endfunction

    // R0 is only written by CONST and stays in 0..127 as the memory base
    task build_program;
        logic [15:0] r;
        logic [1:0]  rd_nz;
        for (int k = 0; k < PROG_LEN; k++) begin
            lcg_state = lcg_next(lcg_state);
            r = lcg_state[31:16];
            rd_nz = 2'd1 + 2'(r[5:4] % 3);
            if (k < 8) begin
                if (k[1:0] == 2'd0) begin
                    prog[k] = {lc4_pkg::OP_CONST, 3'd0, 2'b00, r[6:0]};
                end else begin
                    prog[k] = {lc4_pkg::OP_CONST, 1'b0, k[1:0], r[8:0]};
                end
            end else begin
                case (r[3:0])
                    4'd0: prog[k] = enc_rrr(lc4_pkg::OP_ARITH, 3'b000, rd_nz, r[7:6], r[9:8]);
                    4'd1: prog[k] = enc_rrr(lc4_pkg::OP_ARITH, 3'b001, rd_nz, r[7:6], r[9:8]);
                    4'd2: prog[k] = enc_rrr(lc4_pkg::OP_ARITH, 3'b010, rd_nz, r[7:6], r[9:8]);
                    4'd3: prog[k] = enc_imm6(lc4_pkg::OP_ARITH, rd_nz, r[7:6], {1'b1, r[14:10]});
                    4'd4: prog[k] = enc_rrr(lc4_pkg::OP_LOGIC, 3'b000, rd_nz, r[7:6], r[9:8]);
                    4'd5: prog[k] = enc_rrr(lc4_pkg::OP_LOGIC, 3'b001, rd_nz, r[7:6], r[9:8]);
                    4'd6: prog[k] = enc_rrr(lc4_pkg::OP_LOGIC, 3'b010, rd_nz, r[7:6], r[9:8]);
                    4'd7: prog[k] = enc_rrr(lc4_pkg::OP_LOGIC, 3'b011, rd_nz, r[7:6], r[9:8]);
                    4'd8: prog[k] = enc_imm6(lc4_pkg::OP_LOGIC, rd_nz, r[7:6], {1'b1, r[14:10]});
                    4'd9, 4'd10: prog[k] = enc_imm6(lc4_pkg::OP_LDR, rd_nz, 2'd0, r[15:10]);
                    4'd11, 4'd12: prog[k] = enc_imm6(lc4_pkg::OP_STR, r[9:8], 2'd0, r[15:10]);
                    4'd13: prog[k] = {lc4_pkg::OP_CONST, 1'b0, rd_nz, r[14:6]};
                    4'd14: prog[k] = {lc4_pkg::OP_CONST, 3'd0, 2'b00, r[12:6]};
                    // DIV is outside the kept subset and must retire as a no-op
                    default: prog[k] = enc_rrr(lc4_pkg::OP_ARITH, 3'b011, rd_nz, r[7:6], r[9:8]);
                endcase
            end
        end
    endtask

    // steps ref_regs and shadow_mem through one instruction by the ISA rules
    function automatic void step_reference(input logic [15:0] insn);
        logic [2:0]  d;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] i5;
        logic [15:0] i6;
        logic [15:0] addr;
        d  = insn[11:9];
        a  = ref_regs[insn[8:6]];
        b  = ref_regs[insn[2:0]];
        i5 = {{11{insn[4]}}, insn[4:0]};
        i6 = {{10{insn[5]}}, insn[5:0]};
        addr = a + i6;
        exp_we    = 1'b1;
        exp_wsel  = d;
        exp_wdata = '0;
        exp_dwe   = 1'b0;
        exp_mem   = 1'b0;
        exp_daddr = addr;
        exp_ddata = '0;
        case (insn[15:12])
            lc4_pkg::OP_ARITH: begin
                if (insn[5]) exp_wdata = a + i5;
                else if (insn[4:3] == 2'd0) exp_wdata = a + b;
                else if (insn[4:3] == 2'd1) exp_wdata = a * b;
                else if (insn[4:3] == 2'd2) exp_wdata = a - b;
                else exp_we = 1'b0;
            end
            lc4_pkg::OP_LOGIC: begin
                if (insn[5]) exp_wdata = a & i5;
                else if (insn[4:3] == 2'd0) exp_wdata = a & b;
                else if (insn[4:3] == 2'd1) exp_wdata = ~a;
                else if (insn[4:3] == 2'd2) exp_wdata = a | b;
                else exp_wdata = a ^ b;
            end
            lc4_pkg::OP_LDR: begin
                exp_mem   = 1'b1;
                exp_wdata = shadow_mem[addr[7:0]];
                exp_ddata = exp_wdata;
            end
            lc4_pkg::OP_STR: begin
                exp_we    = 1'b0;
                exp_dwe   = 1'b1;
                exp_mem   = 1'b1;
                exp_ddata = ref_regs[d];
                shadow_mem[addr[7:0]] = exp_ddata;
            end
            lc4_pkg::OP_CONST: exp_wdata = {{7{insn[8]}}, insn[8:0]};
            default: exp_we = 1'b0;
        endcase
        if (exp_we) begin
            ref_regs[d] = exp_wdata;
        end
    endfunction

    // true when cur reads the rd of a load in prev other than as store data
    function automatic logic expect_load_stall(input logic [15:0] prev, input logic [15:0] cur);
        logic uses_rs;
        logic uses_rt;
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        case (cur[15:12])
            lc4_pkg::OP_ARITH: begin
                uses_rs = cur[5] || (cur[4:3] != 2'd3);
                uses_rt = !cur[5] && (cur[4:3] != 2'd3);
            end
            lc4_pkg::OP_LOGIC: begin
                uses_rs = 1'b1;
                uses_rt = !cur[5] && (cur[4:3] != 2'd1);
            end
            lc4_pkg::OP_LDR, lc4_pkg::OP_STR: uses_rs = 1'b1;
            default: ;
        endcase
        if (prev[15:12] != lc4_pkg::OP_LDR) begin
            return 1'b0;
        end
        return (uses_rs && cur[8:6] == prev[11:9]) || (uses_rt && cur[2:0] == prev[11:9]);
    endfunction

    task report_value(input string name, input logic [15:0] expv, input logic [15:0] actv);
        $display("FAIL %s at retirement %0d: expected %h, actual %h", name, ret_idx, expv, actv);
        value_errs++;
    endtask

    task check_cycle;
        logic bubble;
        bubble = (o_test_stall !== lc4_pkg::STALL_NONE);
        if (bubble) begin
            if (o_test_regfile_we !== 1'b0) begin
                report_value("bubble_regfile_we", 0, o_test_regfile_we);
            end
            if (o_test_dmem_we !== 1'b0) report_value("bubble_dmem_we", 0, o_test_dmem_we);
        end
        if (ret_idx == 0 && bubble) begin
            if (o_test_stall !== lc4_pkg::STALL_FILL) begin
                report_value("reset_stall", 2, o_test_stall);
            end
            if (o_dmem_we !== 1'b0) report_value("reset_dmem_we", 0, o_dmem_we);
            if (i_reset && o_cur_pc !== RESET_PC) begin
                report_value("reset_pc", RESET_PC, o_cur_pc);
            end
        end else if (bubble) begin
            if (o_test_stall !== lc4_pkg::STALL_LOAD) begin
                report_value("stall_code", 3, o_test_stall);
            end else if (!stall_due || bubbles_seen != 0) begin
                $display("load-use bubble seen before pc %h where none belongs",
                         RESET_PC + 16'(ret_idx));
                stall_errs++;
            end
            bubbles_seen++;
        end else if (ret_idx < PROG_LEN) begin
            if (stall_due && bubbles_seen == 0) begin
                $display("load-use bubble missing before pc %h", o_test_cur_pc);
                stall_errs++;
            end
            if (o_test_cur_pc !== RESET_PC + 16'(ret_idx)) begin
                report_value("order_pc", RESET_PC + 16'(ret_idx), o_test_cur_pc);
            end
            if (o_test_cur_insn !== prog[ret_idx]) begin
                report_value("order_insn", prog[ret_idx], o_test_cur_insn);
            end
            step_reference(prog[ret_idx]);
            if (o_test_regfile_we !== exp_we) report_value("result_we", exp_we, o_test_regfile_we);
            if (exp_we && o_test_regfile_wsel !== exp_wsel) begin
                report_value("result_wsel", exp_wsel, o_test_regfile_wsel);
            end
            if (exp_we && o_test_regfile_data !== exp_wdata) begin
                report_value("result_data", exp_wdata, o_test_regfile_data);
            end
            if (o_test_dmem_we !== exp_dwe) report_value("mem_we", exp_dwe, o_test_dmem_we);
            if (exp_mem && o_test_dmem_addr !== exp_daddr) begin
                report_value("mem_addr", exp_daddr, o_test_dmem_addr);
            end
            if (exp_mem && o_test_dmem_data !== exp_ddata) begin
                report_value("mem_data", exp_ddata, o_test_dmem_data);
            end
            ret_idx++;
            bubbles_seen = 0;
            if (ret_idx < PROG_LEN) begin
                stall_due = expect_load_stall(prog[ret_idx-1], prog[ret_idx]);
            end else begin
                stall_due = 1'b0;
                done = 1'b1;
            end
        end
    endtask

    // every store must have reached the data memory through the core's port
    task compare_memory;
        for (int i = 0; i < 256; i++) begin
            if (dmem[i] !== shadow_mem[i]) begin
                $display("FAIL final_dmem at word %0d: expected %h, actual %h",
                         i, shadow_mem[i], dmem[i]);
                value_errs++;
            end
        end
    endtask

    // trace outputs are settled by the falling edge
    always @(negedge gwe) begin
        if (cycles > 0 && !done) begin
            check_cycle();
        end
    end

    initial begin
        i_reset         = 1'b1;
        i_cur_insn      = '0;
        i_cur_dmem_data = '0;
        lcg_state       = 32'hb56f_3940;
        build_program();
        for (int i = 0; i < 256; i++) begin
            dmem[i]       = {i[7:0], ~i[7:0]};
            shadow_mem[i] = {i[7:0], ~i[7:0]};
        end
        for (int i = 0; i < 8; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge gwe);
        #2 i_reset = 1'b0;
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge gwe);
        end
        if (!done) begin
            $display("timeout: %0d of %0d instructions retired in %0d cycles",
                     ret_idx, PROG_LEN, MAX_CYCLES);
            other_errs++;
        end else begin
            compare_memory();
        end
        $display("errors: value %0d, stall %0d, other %0d (retired %0d, cycles %0d)",
                 value_errs, stall_errs, other_errs, ret_idx, cycles);
        if (value_errs == 0 && stall_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
lc4_pkg.sv
lc4_pipe_ctl_if.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_fetch_decode.sv
lc4_execute.sv
lc4_mem_wb.sv
lc4_hazard_ctrl.sv
lc4_core.sv
tb_lc4_core.sv
